/* Makefile */
VERILATOR ?= verilator
TOP ?= fpAddSubTb
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
FILELIST ?= tb.f

SRCS = fpFormatPkg.sv fpCtrlPkg.sv fpAlign.sv fpMantissaAdd.sv fpNormalize.sv \
       fpAddSub.sv fpAddSubTb.sv
BIN = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) fpTests.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJDIR)

/* fpAddSub.sv */
// Binary32 adder/subtractor top with four-phase req/ack and two pipeline registers
`timescale 1ns/1ps

module fpAddSub (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              req,
    input  fpCtrlPkg::fpOp                    op,
    input  logic [31:0]                       a,
    input  logic [31:0]                       b,
    output logic                              ack,
    output logic [31:0]                       result,
    output logic [fpFormatPkg::flagWidth-1:0] flags
);
    fpCtrlPkg::hsState state;
    logic [1:0] stageCnt;
    logic capture;
    logic midLoad;
    logic resLoad;

    fpCtrlPkg::fpOp opReg;
    logic [31:0] aReg;
    logic [31:0] bReg;

    logic [fpFormatPkg::expWidth-1:0] alignExp;
    logic [fpFormatPkg::mantWidth-1:0] alignBigMant;
    logic [fpFormatPkg::mantWidth-1:0] alignSmallMant;
    logic alignSign;
    logic alignEffSub;
    logic alignGuard;
    logic alignRound;
    logic alignSticky;
    logic alignSpecial;
    logic [31:0] alignSpecialResult;
    logic [fpFormatPkg::flagWidth-1:0] alignSpecialFlags;
    logic [fpFormatPkg::mantWidth-1:0] addMant;
    logic addCarry;
    logic addSign;
    logic addZero;

    logic [fpFormatPkg::expWidth-1:0] midExp;
    logic [fpFormatPkg::mantWidth-1:0] midMant;
    logic midCarry;
    logic midSign;
    logic midZero;
    logic midGuard;
    logic midRound;
    logic midSticky;
    logic midSpecial;
    logic [31:0] midSpecialResult;
    logic [fpFormatPkg::flagWidth-1:0] midSpecialFlags;
    logic [31:0] normResult;
    logic [fpFormatPkg::flagWidth-1:0] normFlags;

    // Scheduled loads, one per edge after capture
    assign capture = (state == fpCtrlPkg::stIdle) && req;
    assign midLoad = (state == fpCtrlPkg::stBusy) && (stageCnt == 2'd0);
    assign resLoad = (state == fpCtrlPkg::stBusy) && (stageCnt == 2'd1);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= fpCtrlPkg::stIdle;
            stageCnt <= '0;
            ack <= 1'b0;
        end
        else
        begin
            case (state)
                fpCtrlPkg::stIdle:
                begin
                    if (req)
                    begin
                        state <= fpCtrlPkg::stBusy;
                        stageCnt <= '0;
                    end
                end
                fpCtrlPkg::stBusy:
                begin
                    stageCnt <= stageCnt + 2'd1;
                    if (stageCnt == 2'(fpCtrlPkg::pipeDepth - 1))
                    begin
                        ack <= 1'b1;
                        state <= fpCtrlPkg::stDone;
                    end
                end
                // Host holds req to stall here with result frozen
                fpCtrlPkg::stDone:
                begin
                    if (!req)
                    begin
                        ack <= 1'b0;
                        state <= fpCtrlPkg::stWaitLow;
                    end
                end
                fpCtrlPkg::stWaitLow:
                    state <= fpCtrlPkg::stIdle;
                default:
                    state <= fpCtrlPkg::stIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            opReg <= op;
            aReg <= a;
            bReg <= b;
        end
    end

    fpAlign align (
        .op(opReg),
        .a(aReg),
        .b(bReg),
        .bigExp(alignExp),
        .bigMant(alignBigMant),
        .smallMant(alignSmallMant),
        .bigSign(alignSign),
        .effSub(alignEffSub),
        .guardBit(alignGuard),
        .roundBit(alignRound),
        .stickyBit(alignSticky),
        .isSpecial(alignSpecial),
        .specialResult(alignSpecialResult),
        .specialFlags(alignSpecialFlags)
    );

    fpMantissaAdd mantAdd (
        .bigMant(alignBigMant),
        .smallMant(alignSmallMant),
        .effSub(alignEffSub),
        .bigSign(alignSign),
        .sumMant(addMant),
        .carryOut(addCarry),
        .resultSign(addSign),
        .sumZero(addZero)
    );

    // Mid register between add and normalize
    always_ff @(posedge clk)
    begin
        if (midLoad)
        begin
            midExp <= alignExp;
            midMant <= addMant;
            midCarry <= addCarry;
            midSign <= addSign;
            midZero <= addZero;
            midGuard <= alignGuard;
            midRound <= alignRound;
            midSticky <= alignSticky;
            midSpecial <= alignSpecial;
            midSpecialResult <= alignSpecialResult;
            midSpecialFlags <= alignSpecialFlags;
        end
    end

    fpNormalize normalize (
        .bigExp(midExp),
        .sumMant(midMant),
        .carryOut(midCarry),
        .resultSign(midSign),
        .sumZero(midZero),
        .guardBit(midGuard),
        .roundBit(midRound),
        .stickyBit(midSticky),
        .isSpecial(midSpecial),
        .specialResult(midSpecialResult),
        .specialFlags(midSpecialFlags),
        .result(normResult),
        .flags(normFlags)
    );

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            result <= '0;
            flags <= '0;
        end
        else if (resLoad)
        begin
            result <= normResult;
            flags <= normFlags;
        end
    end

endmodule

/* fpAddSubTb.sv */
// Self-checking testbench for the binary32 adder/subtractor over its req/ack handshake
`timescale 1ns/1ps

module fpAddSubTb;
    localparam int numVectors = 26;
    localparam int timeoutCycles = 20 * numVectors + 50;

    logic clk;
    logic rstN;
    logic req;
    fpCtrlPkg::fpOp op;
    logic [31:0] a;
    logic [31:0] b;
    logic ack;
    logic [31:0] result;
    logic [fpFormatPkg::flagWidth-1:0] flags;

    // Op nibble, operand A, operand B, expected result, expected flags
    logic [103:0] vectors [numVectors];
    int cycleCount = 0;
    int passCount;
    int failCount;
    bit testOk;

    fpAddSub UUT (
        .clk(clk),
        .rstN(rstN),
        .req(req),
        .op(op),
        .a(a),
        .b(b),
        .ack(ack),
        .result(result),
        .flags(flags)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // Run limit
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Handshake hung: no ack change within %0d cycles", timeoutCycles);
            $display("Errors found");
            $finish;
        end
    end

    function automatic string flagNames(input logic [fpFormatPkg::flagWidth-1:0] f);
        string s;
        s = "";
        if (f[fpFormatPkg::flagInvalid])
            s = {s, "NV "};
        if (f[fpFormatPkg::flagOverflow])
            s = {s, "OF "};
        if (f[fpFormatPkg::flagUnderflow])
            s = {s, "UF "};
        if (f[fpFormatPkg::flagInexact])
            s = {s, "NX "};
        if (s == "")
            s = "none";
        return s;
    endfunction

    task automatic checkOutputs(input int idx, input logic [31:0] expResult,
                                input logic [fpFormatPkg::flagWidth-1:0] expFlags,
                                input string what);
        if ((result !== expResult) || (flags !== expFlags))
        begin
            $display("Fail at %0t: test %0d %s expected %h [%s] got %h [%s]", $time, idx,
                     what, expResult, flagNames(expFlags), result, flagNames(flags));
            testOk = 1'b0;
        end
    endtask

    task automatic runVector(input int idx);
        logic [103:0] vec;
        logic [31:0] expResult;
        logic [fpFormatPkg::flagWidth-1:0] expFlags;
        logic nanOperand;
        int holdCycles;
        vec = vectors[idx];
        expResult = vec[35:4];
        expFlags = vec[3:0];
        testOk = 1'b1;
        if (ack)
        begin
            $display("Fail at %0t: test %0d ack still high before req", $time, idx);
            testOk = 1'b0;
        end
        op = fpCtrlPkg::fpOp'(vec[100]);
        a = vec[99:68];
        b = vec[67:36];
        // Any NaN operand must come back as the quiet NaN
        nanOperand = ((a[30:23] == 8'hFF) && (a[22:0] != '0)) ||
                     ((b[30:23] == 8'hFF) && (b[22:0] != '0));
        req = 1'b1;
        @(negedge clk);
        while (!ack)
            @(negedge clk);
        checkOutputs(idx, expResult, expFlags, "result");
        if (nanOperand && (result !== fpFormatPkg::canonNan))
        begin
            $display("Fail at %0t: test %0d NaN operand expected %h got %h", $time, idx,
                     fpFormatPkg::canonNan, result);
            testOk = 1'b0;
        end
        // Back-pressure keeps ack high and the result frozen
        holdCycles = $urandom % 4;
        repeat (holdCycles)
        begin
            @(negedge clk);
            if (!ack)
            begin
                $display("Fail at %0t: test %0d ack dropped while req held", $time, idx);
                testOk = 1'b0;
            end
            checkOutputs(idx, expResult, expFlags, "held result");
        end
        req = 1'b0;
        @(negedge clk);
        if (ack)
        begin
            $display("Fail at %0t: test %0d ack did not fall one cycle after req", $time, idx);
            testOk = 1'b0;
        end
        while (ack)
            @(negedge clk);
        if (testOk)
        begin
            $display("Test %0d passed", idx);
            passCount++;
        end
        else
        begin
            $display("Test %0d failed", idx);
            failCount++;
        end
    endtask

    initial
    begin
        int gap;
        rstN = 1'b0;
        req = 1'b0;
        op = fpCtrlPkg::opAdd;
        a = '0;
        b = '0;
        passCount = 0;
        failCount = 0;
        void'($urandom(32'he5f0_ab6a));
        $readmemh("fpTests.txt", vectors);
        repeat (5)
            @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        if ((ack !== 1'b0) || (result !== '0) || (flags !== '0))
        begin
            $display("Fail at %0t: outputs not cleared after reset", $time);
            failCount++;
        end
        for (int i = 0; i < numVectors; i++)
        begin
            runVector(i);
            gap = $urandom % 4;
            repeat (gap)
                @(negedge clk);
        end
        $display("%0d passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* fpAlign.sv */
// Operand unpack, special-value detection and exponent alignment stage
`timescale 1ns/1ps

module fpAlign (
    input  fpCtrlPkg::fpOp                        op,
    input  logic [31:0]                           a,
    input  logic [31:0]                           b,
    output logic [fpFormatPkg::expWidth-1:0]      bigExp,
    output logic [fpFormatPkg::mantWidth-1:0]     bigMant,
    output logic [fpFormatPkg::mantWidth-1:0]     smallMant,
    output logic                                  bigSign,
    output logic                                  effSub,
    output logic                                  guardBit,
    output logic                                  roundBit,
    output logic                                  stickyBit,
    output logic                                  isSpecial,
    output logic [31:0]                           specialResult,
    output logic [fpFormatPkg::flagWidth-1:0]     specialFlags
);
    logic signA;
    logic signB;
    logic [fpFormatPkg::expWidth-1:0] expA;
    logic [fpFormatPkg::expWidth-1:0] expB;
    logic [fpFormatPkg::mantWidth-1:0] mantA;
    logic [fpFormatPkg::mantWidth-1:0] mantB;
    logic nanA;
    logic nanB;
    logic infA;
    logic infB;
    logic aBigger;
    logic [fpFormatPkg::expWidth-1:0] smallExp;
    logic [fpFormatPkg::mantWidth-1:0] smallRaw;
    logic [fpFormatPkg::expWidth-1:0] expDiff;
    logic [fpFormatPkg::expWidth-1:0] shiftAmt;
    logic [2*fpFormatPkg::mantWidth+1:0] shiftedSmall;
    logic [2:0] lostBits;

    // Subtraction flips the sign of b up front
    assign signA = a[31];
    assign signB = b[31] ^ (op == fpCtrlPkg::opSub);
    assign expA = a[30:23];
    assign expB = b[30:23];

    // Subnormals flush to zero here
    assign mantA = (expA == '0) ? '0 : {1'b1, a[fpFormatPkg::fracWidth-1:0]};
    assign mantB = (expB == '0) ? '0 : {1'b1, b[fpFormatPkg::fracWidth-1:0]};

    assign nanA = (expA == fpFormatPkg::expMax) && (a[fpFormatPkg::fracWidth-1:0] != '0);
    assign nanB = (expB == fpFormatPkg::expMax) && (b[fpFormatPkg::fracWidth-1:0] != '0);
    assign infA = (expA == fpFormatPkg::expMax) && (a[fpFormatPkg::fracWidth-1:0] == '0);
    assign infB = (expB == fpFormatPkg::expMax) && (b[fpFormatPkg::fracWidth-1:0] == '0);

    assign effSub = signA ^ signB;
    assign aBigger = (expA > expB) || ((expA == expB) && (mantA >= mantB));

    always_comb
    begin
        if (aBigger)
        begin
            bigExp = expA;
            bigMant = mantA;
            bigSign = signA;
            smallExp = expB;
            smallRaw = mantB;
        end
        else
        begin
            bigExp = expB;
            bigMant = mantB;
            bigSign = signB;
            smallExp = expA;
            smallRaw = mantA;
        end

        // Shifts past 26 only feed sticky, so cap them
        expDiff = bigExp - smallExp;
        if (expDiff > 8'(fpFormatPkg::mantWidth + 2))
            shiftAmt = 8'(fpFormatPkg::mantWidth + 2);
        else
            shiftAmt = expDiff;

        shiftedSmall = {smallRaw, {(fpFormatPkg::mantWidth + 2){1'b0}}} >> shiftAmt;
        lostBits = {shiftedSmall[25], shiftedSmall[24], |shiftedSmall[23:0]};

        // Lost bits borrow from the small mantissa when subtracting
        if (effSub && (lostBits != 3'b000))
        begin
            smallMant = shiftedSmall[2*fpFormatPkg::mantWidth+1:26] + 1'b1;
            {guardBit, roundBit, stickyBit} = -lostBits;
        end
        else
        begin
            smallMant = shiftedSmall[2*fpFormatPkg::mantWidth+1:26];
            {guardBit, roundBit, stickyBit} = lostBits;
        end
    end

    always_comb
    begin
        specialResult = '0;
        specialFlags = '0;
        isSpecial = 1'b1;
        if (nanA || nanB)
            specialResult = fpFormatPkg::canonNan;
        else if (infA && infB && effSub)
        begin
            specialResult = fpFormatPkg::canonNan;
            specialFlags[fpFormatPkg::flagInvalid] = 1'b1;
        end
        else if (infA)
            specialResult = {signA, fpFormatPkg::expMax, {fpFormatPkg::fracWidth{1'b0}}};
        else if (infB)
            specialResult = {signB, fpFormatPkg::expMax, {fpFormatPkg::fracWidth{1'b0}}};
        else if ((mantA == '0) && (mantB == '0))
            specialResult = {signA & signB, 31'b0};    // -0 only for -0 + -0
        else
            isSpecial = 1'b0;
    end

endmodule

/* fpCtrlPkg.sv */
// Opcode and req/ack handshake definitions for the FP adder control path
package fpCtrlPkg;

    typedef enum logic
    {
        opAdd = 1'b0,
        opSub = 1'b1
    } fpOp;

    // Four-phase handshake sequencing
    typedef enum logic [1:0]
    {
        stIdle    = 2'd0,
        stBusy    = 2'd1,
        stDone    = 2'd2,
        stWaitLow = 2'd3
    } hsState;

    // Clock edges from req sampled to ack raised
    localparam int pipeDepth = 3;

endpackage

/* fpFormatPkg.sv */
// Binary32 format constants and exception flag layout for the FP adder
package fpFormatPkg;

    // Field widths of an IEEE 754 single-precision word
    localparam int expWidth = 8;
    localparam int fracWidth = 23;

    // Fraction plus the hidden leading one
    localparam int mantWidth = 24;

    localparam int expBias = 127;

    // Exponent code shared by infinity and NaN
    localparam logic [expWidth-1:0] expMax = 8'hFF;

    // Quiet NaN returned for every NaN result
    localparam logic [31:0] canonNan = 32'h7FC0_0000;

    // Exception flag vector and the position of each flag in it
    localparam int flagWidth = 4;
    localparam int flagInvalid = 0;
    localparam int flagOverflow = 1;
    localparam int flagUnderflow = 2;
    localparam int flagInexact = 3;

endpackage

/* fpMantissaAdd.sv */
// Signed magnitude add or subtract of the aligned mantissas
`timescale 1ns/1ps

module fpMantissaAdd (
    input  logic [fpFormatPkg::mantWidth-1:0] bigMant,
    input  logic [fpFormatPkg::mantWidth-1:0] smallMant,
    input  logic                              effSub,
    input  logic                              bigSign,
    output logic [fpFormatPkg::mantWidth-1:0] sumMant,
    output logic                              carryOut,
    output logic                              resultSign,
    output logic                              sumZero
);
    logic [fpFormatPkg::mantWidth:0] sumFull;

    always_comb
    begin
        // Magnitude order keeps the difference non-negative
        if (effSub)
            sumFull = {1'b0, bigMant} - {1'b0, smallMant};
        else
            sumFull = {1'b0, bigMant} + {1'b0, smallMant};
    end

    assign sumMant = sumFull[fpFormatPkg::mantWidth-1:0];
    assign carryOut = sumFull[fpFormatPkg::mantWidth];

    // Sign follows the larger operand
    assign resultSign = bigSign;
    assign sumZero = (sumFull == '0);

endmodule

/* fpNormalize.sv */
// Result renormalization with round-to-nearest-even and range checks
`timescale 1ns/1ps

module fpNormalize (
    input  logic [fpFormatPkg::expWidth-1:0]  bigExp,
    input  logic [fpFormatPkg::mantWidth-1:0] sumMant,
    input  logic                              carryOut,
    input  logic                              resultSign,
    input  logic                              sumZero,
    input  logic                              guardBit,
    input  logic                              roundBit,
    input  logic                              stickyBit,
    input  logic                              isSpecial,
    input  logic [31:0]                       specialResult,
    input  logic [fpFormatPkg::flagWidth-1:0] specialFlags,
    output logic [31:0]                       result,
    output logic [fpFormatPkg::flagWidth-1:0] flags
);
    logic exactZero;
    logic [fpFormatPkg::mantWidth+1:0] extMant;
    logic [fpFormatPkg::mantWidth+1:0] shiftedMant;
    logic [4:0] zeroCount;
    logic [fpFormatPkg::mantWidth-1:0] normMant;
    logic normGuard;
    logic normRound;
    logic normSticky;
    logic signed [fpFormatPkg::expWidth+1:0] normExp;
    logic signed [fpFormatPkg::expWidth+1:0] finalExp;
    logic roundUp;
    logic inexact;
    logic [fpFormatPkg::mantWidth:0] roundedMant;
    logic [fpFormatPkg::fracWidth-1:0] fracOut;

    // Leading zeros of mantissa plus guard and round
    function automatic logic [4:0] countZeros(input logic [fpFormatPkg::mantWidth+1:0] value);
        logic [4:0] count;
        logic found;
        count = 5'(fpFormatPkg::mantWidth + 2);
        found = 1'b0;
        for (int i = fpFormatPkg::mantWidth + 1; i >= 0; i--)
        begin
            if (value[i] && !found)
            begin
                count = 5'(fpFormatPkg::mantWidth + 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb
    begin
        // A zero sum with pending low bits is still a tiny difference
        exactZero = sumZero && !(guardBit || roundBit || stickyBit);
        extMant = {sumMant, guardBit, roundBit};
        zeroCount = countZeros(extMant);
        shiftedMant = extMant << zeroCount;

        if (carryOut)
        begin
            // Dropped lsb moves into the rounding bits
            normMant = {1'b1, sumMant[fpFormatPkg::mantWidth-1:1]};
            normGuard = sumMant[0];
            normRound = guardBit;
            normSticky = roundBit | stickyBit;
            normExp = 10'(bigExp) + 10'd1;
        end
        else
        begin
            normMant = shiftedMant[fpFormatPkg::mantWidth+1:2];
            normGuard = shiftedMant[1];
            normRound = shiftedMant[0];
            normSticky = stickyBit;
            normExp = 10'(bigExp) - 10'(zeroCount);
        end

        // Nearest even, ties go to an even lsb
        roundUp = normGuard && (normRound || normSticky || normMant[0]);
        inexact = normGuard || normRound || normSticky;
        roundedMant = {1'b0, normMant} + 25'(roundUp);

        // Rounding carry bumps the exponent
        finalExp = normExp + 10'(roundedMant[fpFormatPkg::mantWidth]);
        if (roundedMant[fpFormatPkg::mantWidth])
            fracOut = roundedMant[fpFormatPkg::mantWidth-1:1];
        else
            fracOut = roundedMant[fpFormatPkg::fracWidth-1:0];
    end

    always_comb
    begin
        flags = '0;
        if (isSpecial)
        begin
            result = specialResult;
            flags = specialFlags;
        end
        else if (exactZero)
            result = '0;
        else if (finalExp <= 0)
        begin
            result = {resultSign, 31'b0};
            flags[fpFormatPkg::flagUnderflow] = 1'b1;
            flags[fpFormatPkg::flagInexact] = 1'b1;
        end
        else if (finalExp >= int'(fpFormatPkg::expMax))
        begin
            result = {resultSign, fpFormatPkg::expMax, {fpFormatPkg::fracWidth{1'b0}}};
            flags[fpFormatPkg::flagOverflow] = 1'b1;
            flags[fpFormatPkg::flagInexact] = 1'b1;
        end
        else
        begin
            result = {resultSign, finalExp[fpFormatPkg::expWidth-1:0], fracOut};
            flags[fpFormatPkg::flagInexact] = inexact;
        end
    end

endmodule

/* fpTests.txt */
// Columns: op (0 add, 1 sub), operand A, operand B, expected result, expected flags
// Flags: bit0 invalid, bit1 overflow, bit2 underflow, bit3 inexact
0_3F800000_3F800000_40000000_0
0_3F800000_40000000_40400000_0
1_40400000_3F800000_40000000_0
0_3FC00000_40100000_40700000_0
1_40A00000_40E00000_C0000000_0
1_3F800000_3F800000_00000000_0
0_80000000_80000000_80000000_0
0_00000000_80000000_00000000_0
0_40200000_C0200000_00000000_0
0_3F800000_33800000_3F800000_8
0_3F800001_33800000_3F800002_8
0_3F800000_33C00000_3F800001_8
0_3FFFFFFF_33800000_40000000_8
1_3F800000_33000000_3F800000_8
0_3F800000_00800000_3F800000_8
0_7F7FFFFF_7F7FFFFF_7F800000_A
1_FF7FFFFF_7F7FFFFF_FF800000_A
0_7F7FFFFF_73000000_7F800000_A
1_00800001_00800000_00000000_C
1_00800000_00800001_80000000_C
0_00400000_3F800000_3F800000_0
0_00400000_00200000_00000000_0
0_7F800001_3F800000_7FC00000_0
1_7F800000_7F800000_7FC00000_1
0_FF800000_3F800000_FF800000_0
1_3F800000_7F800000_FF800000_0

/* tb.f */
fpFormatPkg.sv
fpCtrlPkg.sv
fpAlign.sv
fpMantissaAdd.sv
fpNormalize.sv
fpAddSub.sv
fpAddSubTb.sv
